// File: rtl/esaxi_pkg.sv
package esaxi_pkg;

   // ##########################################################
   // plain vector types
   // ##########################################################

   typedef logic [31:0] axi_addr_t;  // byte address
   typedef logic [31:0] axi_data_t;  // one data word
   typedef logic [3:0]  axi_strb_t;  // byte lane strobes
   typedef logic [11:0] axi_id_t;    // transaction id
   typedef logic [7:0]  axi_len_t;   // beats minus one
   typedef logic [2:0]  axi_size_t;  // log2 of bytes per beat
   typedef logic [1:0]  axi_burst_t; // burst type
   typedef logic [1:0]  axi_resp_t;  // response code
   typedef logic [1:0]  datamode_t;  // mesh size, 0=byte 1=half 2=word

   // codes and fixed values
   localparam axi_burst_t burst_incr   = 2'd1;
   localparam axi_resp_t  resp_okay    = 2'd0;
   localparam axi_resp_t  resp_slverr  = 2'd2;
   localparam axi_data_t  timeout_data = 32'hdeadbeef; // returned when no answer comes

   // ##########################################################
   // channel and request structs
   // ##########################################################

   typedef struct packed {
      axi_id_t    id;
      axi_addr_t  addr;
      axi_len_t   len;
      axi_size_t  size;
      axi_burst_t burst;
   } axi_aw_t; // 57 bits

   typedef struct packed {
      axi_id_t    id;
      axi_addr_t  addr;
      axi_len_t   len;
      axi_size_t  size;
      axi_burst_t burst;
   } axi_ar_t; // 57 bits

   typedef struct packed {
      axi_data_t data;
      axi_strb_t strb;
      logic      last;
   } axi_w_t; // 37 bits

   // outbound write, 66 bits
   typedef struct packed {
      axi_addr_t dstaddr;
      axi_data_t data;
      datamode_t datamode;
   } mesh_wr_t;

   // outbound read, srcaddr is where the answer goes
   typedef struct packed {
      axi_addr_t dstaddr;
      axi_addr_t srcaddr;
      datamode_t datamode;
   } mesh_rd_t;

endpackage

// File: rtl/esaxi_write.sv
`timescale 1ns/10ps

module esaxi_write
(
   input  logic                s_axi_aclk,
   input  logic                s_axi_aresetn,
   // write address
   input  esaxi_pkg::axi_aw_t  aw,
   input  logic                awvalid,
   output logic                awready,
   // write data
   input  esaxi_pkg::axi_w_t   w,
   input  logic                wvalid,
   output logic                wready,
   // write response
   output esaxi_pkg::axi_id_t  bid,
   output esaxi_pkg::axi_resp_t bresp,
   output logic                bvalid,
   input  logic                bready,
   // mesh side
   input  logic                txwr_wait,
   output logic                txwr_access,
   output esaxi_pkg::mesh_wr_t txwr_req
);
   import esaxi_pkg::*;

   logic       aw_hs;
   logic       w_hs;
   logic       last_wr_beat;
   logic       write_active;  // set by aw, cleared by wlast
   axi_addr_t  aw_addr_q;     // steps by a word per beat on incr
   axi_size_t  aw_size_q;
   axi_burst_t aw_burst_q;
   mesh_wr_t   wr_align;      // beat after strobe alignment
   mesh_wr_t   wr_stage_q;    // first pipeline stage
   logic       pre_wr_en;

   assign aw_hs        = awvalid & awready;
   assign w_hs         = wvalid & wready;
   assign last_wr_beat = w_hs & w.last;
   assign bresp        = resp_okay; // writes never fail

   // ##########################################################
   // address and response control
   // ##########################################################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         awready      <= 1'b1;
         write_active <= 1'b0;
         wready       <= 1'b0;
         bvalid       <= 1'b0;
      end
      else
      begin
         // idle again only once b has been taken
         if (!awready && !write_active && !bvalid)
            awready <= 1'b1;
         else if (aw_hs)
            awready <= 1'b0;

         if (aw_hs)
            write_active <= 1'b1;
         else if (last_wr_beat)
            write_active <= 1'b0;

         if (last_wr_beat)
            wready <= 1'b0;
         else if (write_active)
            wready <= !txwr_wait; // one cycle behind the mesh

         if (last_wr_beat)
            bvalid <= 1'b1;
         else if (bvalid && bready)
            bvalid <= 1'b0;
      end
   end

   // captured burst info, stepped per beat
   always_ff @(posedge s_axi_aclk)
   begin
      if (aw_hs)
      begin
         bid        <= aw.id;
         aw_addr_q  <= aw.addr;
         aw_size_q  <= aw.size;
         aw_burst_q <= aw.burst;
      end
      else if (w_hs && aw_burst_q == burst_incr)
      begin
         aw_addr_q[31:2] <= aw_addr_q[31:2] + 30'd1;
         aw_addr_q[1:0]  <= 2'b00; // word aligned after first beat
      end
   end

   // ##########################################################
   // strobe alignment and request pipeline
   // ##########################################################

   always_comb
   begin
      wr_align.datamode      = aw_size_q[1:0];
      wr_align.dstaddr[31:2] = aw_addr_q[31:2];
      // lowest set strobe picks the lane
      if (w.strb[0])
      begin
         wr_align.data         = w.data;
         wr_align.dstaddr[1:0] = 2'd0;
      end
      else if (w.strb[1])
      begin
         wr_align.data         = {8'd0, w.data[31:8]};
         wr_align.dstaddr[1:0] = 2'd1;
      end
      else if (w.strb[2])
      begin
         wr_align.data         = {16'd0, w.data[31:16]};
         wr_align.dstaddr[1:0] = 2'd2;
      end
      else
      begin
         wr_align.data         = {24'd0, w.data[31:24]}; // top byte only
         wr_align.dstaddr[1:0] = 2'd3;
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         pre_wr_en   <= 1'b0;
         txwr_access <= 1'b0;
      end
      else
      begin
         pre_wr_en   <= w_hs;      // stage 1
         txwr_access <= pre_wr_en; // stage 2
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      wr_stage_q <= wr_align;
      txwr_req   <= wr_stage_q;
   end

endmodule

// File: rtl/esaxi_read.sv
`timescale 1ns/10ps

module esaxi_read
#(
   parameter esaxi_pkg::axi_addr_t return_addr = 32'h99900000
)
(
   input  logic                 s_axi_aclk,
   input  logic                 s_axi_aresetn,
   // read address
   input  esaxi_pkg::axi_ar_t   ar,
   input  logic                 arvalid,
   output logic                 arready,
   // read data
   output esaxi_pkg::axi_id_t   rid,
   output esaxi_pkg::axi_data_t rdata,
   output esaxi_pkg::axi_resp_t rresp,
   output logic                 rlast,
   output logic                 rvalid,
   input  logic                 rready,
   // mesh side
   input  logic                 rxrr_access,
   input  esaxi_pkg::axi_data_t rxrr_data,
   output logic                 txrd_access,
   output esaxi_pkg::mesh_rd_t  txrd_req,
   // timer
   input  logic                 timeout_fire,
   output logic                 ar_accept
);
   import esaxi_pkg::*;

   logic       r_hs;
   logic       last_rd_beat;
   logic       read_active; // one read in flight at most
   logic       ractive_q;   // for the rising edge of read_active
   logic       rnext;       // next beat may go out
   axi_addr_t  ar_addr_q;
   axi_len_t   beats_left;  // remaining beats minus one
   axi_size_t  ar_size_q;
   axi_burst_t ar_burst_q;
   axi_data_t  ret_data;

   assign ar_accept    = arvalid & arready;
   assign r_hs         = rvalid & rready;
   assign last_rd_beat = r_hs & rlast;

   // ##########################################################
   // ar channel and beat counter
   // ##########################################################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         arready     <= 1'b0;
         read_active <= 1'b0;
         beats_left  <= '0;
         rlast       <= 1'b0;
      end
      else
      begin
         if (!arready && !read_active)
            arready <= 1'b1;
         else if (ar_accept)
            arready <= 1'b0;

         if (ar_accept)
            read_active <= 1'b1;
         else if (last_rd_beat)
            read_active <= 1'b0;

         if (ar_accept)
         begin
            beats_left <= ar.len;
            rlast      <= (ar.len == '0); // single beat read
         end
         else if (r_hs)
         begin
            beats_left <= beats_left - 8'd1;
            if (beats_left == 8'd1)
               rlast <= 1'b1;
         end
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (ar_accept)
      begin
         rid        <= ar.id;
         ar_addr_q  <= ar.addr;
         ar_size_q  <= ar.size;
         ar_burst_q <= ar.burst;
      end
      else if (r_hs && ar_burst_q == burst_incr) // burst type as captured with ar
      begin
         ar_addr_q[31:2] <= ar_addr_q[31:2] + 30'd1;
         ar_addr_q[1:0]  <= 2'b00;
      end
   end

   // ##########################################################
   // outbound requests, one per beat
   // ##########################################################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         ractive_q   <= 1'b0;
         rnext       <= 1'b0;
         txrd_access <= 1'b0;
      end
      else
      begin
         ractive_q   <= read_active;
         rnext       <= r_hs & !rlast;
         txrd_access <= (read_active & !ractive_q) | rnext; // first beat or next one
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      txrd_req.dstaddr  <= ar_addr_q;
      txrd_req.srcaddr  <= return_addr; // answers come back here
      txrd_req.datamode <= ar_size_q[1:0];
   end

   // ##########################################################
   // r channel
   // ##########################################################

   assign ret_data = timeout_fire ? timeout_data : rxrr_data;

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         rvalid <= 1'b0;
      else if (rxrr_access || timeout_fire)
         rvalid <= 1'b1;
      else if (r_hs)
         rvalid <= 1'b0;
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (rxrr_access || timeout_fire)
      begin
         rresp <= timeout_fire ? resp_slverr : resp_okay;
         case (ar_size_q[1:0])
            2'b00:   rdata <= {4{ret_data[7:0]}};  // byte on every lane
            2'b01:   rdata <= {2{ret_data[15:0]}}; // half on both halves
            default: rdata <= ret_data;
         endcase
      end
   end

endmodule

// File: rtl/esaxi_timeout.sv
`timescale 1ns/10ps

module esaxi_timeout
#(
   parameter int timeout_width = 16
)
(
   input  logic s_axi_aclk,
   input  logic s_axi_aresetn,
   input  logic ar_accept,   // new read started
   input  logic rxrr_access, // answer arrived
   output logic timeout_fire
);
   import esaxi_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_armed,
      st_expired
   } timeout_state_t;

   timeout_state_t           state;
   logic [timeout_width-1:0] count;
   logic                     count_zero;

   assign count_zero   = (count == '0);
   assign timeout_fire = (state == st_expired); // lasts one cycle

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         state <= st_idle;
         count <= '1;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               count <= '1; // reload while waiting
               if (ar_accept)
                  state <= st_armed;
            end
            st_armed:
            begin
               count <= count - 1'b1;
               if (rxrr_access)
                  state <= st_idle;
               else if (count_zero)
                  state <= st_expired;
            end
            default: state <= st_idle; // expired, back after the pulse
         endcase
      end
   end

endmodule

// File: rtl/esaxi_top.sv
`timescale 1ns/10ps

module esaxi_top
#(
   parameter esaxi_pkg::axi_addr_t return_addr   = 32'h99900000,
   parameter int                   timeout_width = 16
)
(
   input  logic                 s_axi_aclk,
   input  logic                 s_axi_aresetn,
   // axi slave channels
   input  esaxi_pkg::axi_aw_t   aw,
   input  logic                 awvalid,
   output logic                 awready,
   input  esaxi_pkg::axi_w_t    w,
   input  logic                 wvalid,
   output logic                 wready,
   output esaxi_pkg::axi_id_t   bid,
   output esaxi_pkg::axi_resp_t bresp,
   output logic                 bvalid,
   input  logic                 bready,
   input  esaxi_pkg::axi_ar_t   ar,
   input  logic                 arvalid,
   output logic                 arready,
   output esaxi_pkg::axi_id_t   rid,
   output esaxi_pkg::axi_data_t rdata,
   output esaxi_pkg::axi_resp_t rresp,
   output logic                 rlast,
   output logic                 rvalid,
   input  logic                 rready,
   // mesh side
   input  logic                 txwr_wait,
   output logic                 txwr_access,
   output esaxi_pkg::mesh_wr_t  txwr_req,
   output logic                 txrd_access,
   output esaxi_pkg::mesh_rd_t  txrd_req,
   input  logic                 rxrr_access,
   input  esaxi_pkg::axi_data_t rxrr_data
);
   import esaxi_pkg::*;

   logic ar_accept;    // read -> timer
   logic timeout_fire; // timer -> read

   esaxi_write u_write
   (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .aw            (aw),
      .awvalid       (awvalid),
      .awready       (awready),
      .w             (w),
      .wvalid        (wvalid),
      .wready        (wready),
      .bid           (bid),
      .bresp         (bresp),
      .bvalid        (bvalid),
      .bready        (bready),
      .txwr_wait     (txwr_wait),
      .txwr_access   (txwr_access),
      .txwr_req      (txwr_req)
   );

   esaxi_read #(
      .return_addr (return_addr)
   ) u_read
   (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .ar            (ar),
      .arvalid       (arvalid),
      .arready       (arready),
      .rid           (rid),
      .rdata         (rdata),
      .rresp         (rresp),
      .rlast         (rlast),
      .rvalid        (rvalid),
      .rready        (rready),
      .rxrr_access   (rxrr_access),
      .rxrr_data     (rxrr_data),
      .txrd_access   (txrd_access),
      .txrd_req      (txrd_req),
      .timeout_fire  (timeout_fire),
      .ar_accept     (ar_accept)
   );

   // covers the first beat of each read
   esaxi_timeout #(
      .timeout_width (timeout_width)
   ) u_timeout
   (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .ar_accept     (ar_accept),
      .rxrr_access   (rxrr_access),
      .timeout_fire  (timeout_fire)
   );

endmodule

// File: test/esaxi_asserts.sv
`timescale 1ns/10ps

module esaxi_asserts
(
   input logic s_axi_aclk,
   input logic s_axi_aresetn,
   input logic bvalid,
   input logic bready,
   input logic rvalid,
   input logic rready,
   input logic txrd_access,
   input logic wready,
   input logic txwr_wait
);

   // ##########################################################
   // channel hold rules
   // ##########################################################

   a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   a_rvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      rvalid && !rready |=> rvalid)
      else $error("rvalid dropped before rready");

   // one read outstanding, no new request while r waits
   a_no_txrd_in_r: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      rvalid |-> !txrd_access)
      else $error("txrd_access while rvalid pending");

   a_wready_wait: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      txwr_wait && $past(txwr_wait) |-> !wready) // one cycle lag allowed
      else $error("wready high after two cycles of txwr_wait");

endmodule

bind esaxi_top esaxi_asserts u_asserts
(
   .s_axi_aclk    (s_axi_aclk),
   .s_axi_aresetn (s_axi_aresetn),
   .bvalid        (bvalid),
   .bready        (bready),
   .rvalid        (rvalid),
   .rready        (rready),
   .txrd_access   (txrd_access),
   .wready        (wready),
   .txwr_wait     (txwr_wait)
);

// File: test/tb_esaxi.sv
`timescale 1ns/10ps

module tb_esaxi;
   import esaxi_pkg::*;

   localparam int        rec_words   = 15;           // words per golden record
   localparam int        max_recs    = 32;
   localparam int        tw          = 6;            // timeout counter width
   localparam axi_addr_t return_addr = 32'h99900000; // default of the dut

   logic       s_axi_aclk;
   logic       s_axi_aresetn;
   axi_aw_t    aw;
   logic       awvalid;
   logic       awready;
   axi_w_t     w;
   logic       wvalid;
   logic       wready;
   axi_id_t    bid;
   axi_resp_t  bresp;
   logic       bvalid;
   logic       bready;
   axi_ar_t    ar;
   logic       arvalid;
   logic       arready;
   axi_id_t    rid;
   axi_data_t  rdata;
   axi_resp_t  rresp;
   logic       rlast;
   logic       rvalid;
   logic       rready;
   logic       txwr_wait;
   logic       txwr_access;
   mesh_wr_t   txwr_req;
   logic       txrd_access;
   mesh_rd_t   txrd_req;
   logic       rxrr_access;
   axi_data_t  rxrr_data;

   logic [31:0] golden [0:rec_words*max_recs-1];
   mesh_wr_t    wr_q[$]; // collected mesh writes
   mesh_rd_t    rd_q[$]; // collected mesh reads
   integer      seed;
   int          b_count;
   int          errors;
   int          checks;
   int          cycles;
   int          limit;

   esaxi_top #(
      .timeout_width (tw)
   ) u_dut (.*);

   always #5 s_axi_aclk = ~s_axi_aclk;

   // ##########################################################
   // mesh side monitor and run limit
   // ##########################################################

   always @(posedge s_axi_aclk)
   begin
      if (txwr_access)
         wr_q.push_back(txwr_req);
      if (txrd_access)
         rd_q.push_back(txrd_req);
      if (bvalid && bready)
         b_count = b_count + 1;
      cycles = cycles + 1;
      if (limit > 0 && cycles > limit)
      begin
         $display("timeout, run stopped after %0d cycles without finishing", cycles);
         $display("Checks failed");
         $finish;
      end
   end

   task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks = checks + 1;
      if (got !== exp)
      begin
         errors = errors + 1;
         $display("mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic idle_cycles(input int max_gap);
      int n;
      n = int'($unsigned($random(seed)) % 32'(max_gap + 1));
      repeat (n) @(negedge s_axi_aclk);
   endtask

   // lowest strobe set decides the lane
   function automatic logic [1:0] lowest_lane(input axi_strb_t strb);
      if (strb[0])
         return 2'd0;
      else if (strb[1])
         return 2'd1;
      else if (strb[2])
         return 2'd2;
      else
         return 2'd3;
   endfunction

   // ##########################################################
   // write test
   // ##########################################################

   task automatic run_write(input int base);
      axi_addr_t addr;
      axi_id_t   id;
      int        len;
      axi_size_t size;
      axi_strb_t strb;
      int        b_before;
      mesh_wr_t  req;
      addr     = golden[base+1];
      id       = golden[base+2][11:0];
      len      = int'(golden[base+3][7:0]);
      size     = golden[base+4][2:0];
      strb     = golden[base+5][3:0];
      b_before = b_count;
      @(negedge s_axi_aclk);
      aw      = '{id: id, addr: addr, len: axi_len_t'(len), size: size, burst: burst_incr};
      awvalid = 1'b1;
      while (!awready)
         @(negedge s_axi_aclk);
      @(negedge s_axi_aclk); // handshake done at the edge before
      awvalid = 1'b0;
      for (int i = 0; i <= len; i++)
      begin
         idle_cycles(2);
         compare("bvalid before last beat", 32'(bvalid), 32'd0); // b only after wlast
         w         = '{data: golden[base+6+i], strb: strb, last: (i == len)};
         wvalid    = 1'b1;
         txwr_wait = (($random(seed) & 3) == 0); // mesh busy now and then
         while (!wready)
         begin
            @(negedge s_axi_aclk);
            txwr_wait = 1'b0;
         end
         @(negedge s_axi_aclk);
         wvalid = 1'b0;
      end
      txwr_wait = 1'b0;
      while (!bvalid)
         @(negedge s_axi_aclk);
      compare("bid", 32'(bid), 32'(id));
      compare("bresp", 32'(bresp), golden[base+14]);
      idle_cycles(2);
      bready = 1'b1; // held so any further response is counted
      @(negedge s_axi_aclk);
      while (wr_q.size() < len + 1)
         @(negedge s_axi_aclk);
      for (int i = 0; i <= len; i++)
      begin
         req = wr_q.pop_front();
         compare("txwr dstaddr", req.dstaddr, {addr[31:2] + 30'(i), lowest_lane(strb)});
         compare("txwr data", req.data, golden[base+10+i]);
         compare("txwr datamode", 32'(req.datamode), 32'(size[1:0]));
      end
      repeat (3) @(negedge s_axi_aclk);
      bready = 1'b0;
      compare("b response count", 32'(b_count - b_before), 32'd1);
      compare("extra txwr requests", 32'(wr_q.size()), 32'd0);
   endtask

   // ##########################################################
   // read test, answer low means the mesh stays silent
   // ##########################################################

   task automatic run_read(input int base, input logic answer);
      axi_addr_t addr;
      axi_id_t   id;
      int        len;
      axi_size_t size;
      mesh_rd_t  req;
      axi_addr_t exp_addr;
      addr = golden[base+1];
      id   = golden[base+2][11:0];
      len  = int'(golden[base+3][7:0]);
      size = golden[base+4][2:0];
      @(negedge s_axi_aclk);
      ar      = '{id: id, addr: addr, len: axi_len_t'(len), size: size, burst: burst_incr};
      arvalid = 1'b1;
      while (!arready)
         @(negedge s_axi_aclk);
      @(negedge s_axi_aclk);
      arvalid = 1'b0;
      for (int i = 0; i <= len; i++)
      begin
         while (rd_q.size() == 0)
            @(negedge s_axi_aclk);
         req      = rd_q.pop_front();
         exp_addr = (i == 0) ? addr : {addr[31:2] + 30'(i), 2'b00};
         compare("txrd dstaddr", req.dstaddr, exp_addr);
         compare("txrd srcaddr", req.srcaddr, return_addr);
         compare("txrd datamode", 32'(req.datamode), 32'(size[1:0]));
         if (answer)
         begin
            idle_cycles(3);
            rxrr_access = 1'b1;
            rxrr_data   = golden[base+6+i];
            @(negedge s_axi_aclk);
            rxrr_access = 1'b0;
         end
         while (!rvalid)
            @(negedge s_axi_aclk);
         compare("rdata", rdata, golden[base+10+i]);
         compare("rresp", 32'(rresp), golden[base+14]);
         compare("rlast", 32'(rlast), 32'(i == len));
         compare("rid", 32'(rid), 32'(id));
         idle_cycles(2);
         compare("txrd before beat taken", 32'(rd_q.size()), 32'd0); // next one waits
         rready = 1'b1;
         @(negedge s_axi_aclk);
         rready = 1'b0;
      end
   endtask

   // ##########################################################
   // main sequence
   // ##########################################################

   initial
   begin
      int n_recs;
      int base;
      int op;
      int err_before;
      s_axi_aclk    = 1'b0;
      s_axi_aresetn = 1'b0;
      aw            = '0;
      awvalid       = 1'b0;
      w             = '0;
      wvalid        = 1'b0;
      bready        = 1'b0;
      ar            = '0;
      arvalid       = 1'b0;
      rready        = 1'b0;
      txwr_wait     = 1'b0;
      rxrr_access   = 1'b0;
      rxrr_data     = '0;
      seed          = 32'h4c79;
      b_count       = 0;
      errors        = 0;
      checks        = 0;
      cycles        = 0;
      limit         = 0;
      for (int a = 0; a < rec_words * max_recs; a++)
         golden[a] = '0;
      $readmemh("test/esaxi_golden.txt", golden);
      n_recs = 0;
      while (n_recs < max_recs && golden[n_recs*rec_words] != 32'd0)
         n_recs = n_recs + 1;
      limit = n_recs * (2**tw + 60);
      if (n_recs == 0)
      begin
         $display("no records found in test/esaxi_golden.txt");
         errors = errors + 1;
      end
      repeat (10) @(negedge s_axi_aclk);
      s_axi_aresetn = 1'b1;
      for (int r = 0; r < n_recs; r++)
      begin
         base       = r * rec_words;
         op         = int'(golden[base]);
         err_before = errors;
         case (op)
            1:       run_write(base);
            2:       run_read(base, 1'b1);
            3:       run_read(base, 1'b0); // timer must answer
            default:
            begin
               $display("record %0d has unknown operation %0d", r, op);
               errors = errors + 1;
            end
         endcase
         $display("test %0d op %0d finished with %0d errors", r, op, errors - err_before);
      end
      repeat (5) @(negedge s_axi_aclk);
      $display("%0d tests, %0d checks, %0d errors", n_recs, checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// File: test/esaxi_golden.txt
// op addr id len size strb, data0..data3 (write data or mesh return), exp0..exp3, resp
// op 1 = write burst, 2 = read burst, 3 = read that the mesh never answers
// single word write
1 80000010 123 0 2 f 11223344 0 0 0 11223344 0 0 0 0
// strobe alignment, lanes 1 2 3
1 80000020 2a1 0 0 2 aabbccdd 0 0 0 00aabbcc 0 0 0 0
1 80000024 2a2 0 1 4 aabbccdd 0 0 0 0000aabb 0 0 0 0
1 80000028 2a3 0 0 8 aabbccdd 0 0 0 000000aa 0 0 0 0
// incrementing write burst of four
1 80000100 0c4 3 2 f 01010101 02020202 03030303 04040404 01010101 02020202 03030303 04040404 0
// single reads, word byte half
2 80000200 03a 0 2 0 12345678 0 0 0 12345678 0 0 0 0
2 80000204 03b 0 0 0 123456a5 0 0 0 a5a5a5a5 0 0 0 0
2 80000206 03c 0 1 0 7654c3d2 0 0 0 c3d2c3d2 0 0 0 0
// incrementing read burst, len 3
2 80000300 03d 3 2 0 a0a0a0a0 b1b1b1b1 c2c2c2c2 d3d3d3d3 a0a0a0a0 b1b1b1b1 c2c2c2c2 d3d3d3d3 0
// read timeout, then a normal read
3 80000400 03e 0 2 0 0 0 0 0 deadbeef 0 0 0 2
2 80000404 03f 0 2 0 cafef00d 0 0 0 cafef00d 0 0 0 0

// File: src.f
rtl/esaxi_pkg.sv
rtl/esaxi_write.sv
rtl/esaxi_read.sv
rtl/esaxi_timeout.sv
rtl/esaxi_top.sv
test/esaxi_asserts.sv
test/tb_esaxi.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_esaxi
FLAGS     ?= --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"

test:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f src.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
